// ==== tb.f ====
+incdir+include
design/arith_pkg.sv
design/unit_if.sv
design/alu_short.sv
design/mul_pipe.sv
design/div_core.sv
design/div_sign.sv
design/arith_ctrl.sv
design/arith_unit.sv
bench/tb_clock.sv
bench/tb_arith_unit.sv

// ==== include/tb_ref.svh ====
// ----------------------------------------
// Arithmetic unit reference model
// Random source, expected results and
// compare tasks for the testbench
// ----------------------------------------
`ifndef TB_REF_SVH
`define TB_REF_SVH

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

// One Galois step per bit taken
function automatic logic lfsr_bit();
  logic out;
  out        = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out) begin
    lfsr_state = lfsr_state ^ LFSR_TAPS;
  end
  return out;
endfunction

function automatic word_t random_bits(input int n);
  word_t w;
  w = '0;
  for (int i = 0; i < n; i++) begin
    w = {w[DATA_W-2:0], lfsr_bit()};
  end
  return w;
endfunction

// Vacated bits take the fill bit
function automatic word_t shift_ref(input word_t x, input shamt_t n, input logic arith);
  word_t r;
  for (int i = 0; i < DATA_W; i++) begin
    r[i] = (i + n < DATA_W) ? x[i + n] : (arith & x[DATA_W-1]);
  end
  return r;
endfunction

// Expected {result_ext, result}
function automatic dword_t ref_result(input op_e o, input logic sgn, input word_t x,
                                      input word_t y);
  longint sx;
  longint sy;
  word_t  lo;
  word_t  hi;
  sx = sgn ? longint'($signed(x)) : longint'(x);
  sy = sgn ? longint'($signed(y)) : longint'(y);
  hi = '0;
  case (o)
    OP_ADD: lo = x + y;
    OP_SUB: lo = x - y;
    OP_SLT: lo = (sx < sy) ? 1 : 0;
    OP_SHR: lo = shift_ref(x, y[4:0], sgn);
    OP_MUL: {hi, lo} = sx * sy;
    OP_DIV: begin
      if (y == '0) begin
        lo = '1;
        hi = x;
      end else begin
        // Quotient truncates and the remainder follows the dividend
        lo = word_t'(sx / sy);
        hi = word_t'(sx % sy);
      end
    end
    default: lo = '0;
  endcase
  return {hi, lo};
endfunction

// Unit latency plus the registered top-level result
function automatic int ref_latency(input op_e o);
  case (o)
    OP_MUL:  return MUL_LAT + 1;
    OP_DIV:  return DIV_LAT + 1;
    default: return ALU_LAT + 1;
  endcase
endfunction

task automatic check_word(input string what, input word_t got, input word_t exp);
  if (got !== exp) begin
    $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
    stop_on_error();
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAIL %0d ns: %s is %b, expected %b", $time, what, got, exp);
    stop_on_error();
  end
endtask

task automatic check_latency(input int got, input int exp);
  if (got != exp) begin
    $display("FAIL %0d ns: done after %0d cycles, expected %0d", $time, got, exp);
    stop_on_error();
  end
endtask

`endif

// ==== bench/tb_arith_unit.sv ====
// ----------------------------------------
// Arithmetic unit testbench
// Directed corners and random operations
// checked against a reference model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_arith_unit import arith_pkg::*; ();

  localparam int          CLK_NS       = 8;
  localparam int          RST_CYCLES   = 5;
  localparam int          N_DIRECTED   = 13;
  localparam int          N_RANDOM     = 200;
  localparam int          LIMIT_CYCLES = (N_DIRECTED + N_RANDOM) * (DIV_LAT + 4) + RST_CYCLES;
  localparam logic [31:0] LFSR_SEED    = 32'hd37b7f2a;

  logic        clk;
  logic        rst_n;
  logic        start;
  op_e         op;
  logic        is_signed;
  word_t       a;
  word_t       b;
  logic        done;
  logic        busy;
  word_t       result;
  word_t       result_ext;
  logic [31:0] lfsr_state = LFSR_SEED;
  int          cycle = 0;
  dword_t      exp_q[$];
  int          lat_q[$];
  int          start_q[$];

  `include "tb_ref.svh"

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));

  arith_unit uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .op         (op),
    .is_signed  (is_signed),
    .a          (a),
    .b          (b),
    .done       (done),
    .busy       (busy),
    .result     (result),
    .result_ext (result_ext)
  );

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic word_t pick_operand();
    case (random_bits(3))
      0:       return '0;
      1:       return '1;
      2:       return 32'h8000_0000;
      3:       return random_bits(4);
      default: return random_bits(DATA_W);
    endcase
  endfunction

  function automatic op_e pick_op();
    word_t r;
    r = random_bits(3);
    if (r > 5) begin
      r = r - 6;
    end
    return op_e'(r[2:0]);
  endfunction

  // Called and returns at a rising edge
  task automatic run_op(input op_e o, input logic s, input word_t x, input word_t y);
    int gap;
    exp_q.push_back(ref_result(o, s, x, y));
    lat_q.push_back(ref_latency(o));
    start     <= 1'b1;
    op        <= o;
    is_signed <= s;
    a         <= x;
    b         <= y;
    @(posedge clk);
    start <= 1'b0;
    @(posedge done);
    // A zero gap starts the next operation in the done cycle
    gap = lfsr_bit() ? 0 : 1 + lfsr_bit();
    repeat (gap) @(posedge clk);
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    op_e   ro;
    logic  rs;
    word_t ra;
    word_t rb;
    start     <= 1'b0;
    op        <= OP_ADD;
    is_signed <= 1'b0;
    a         <= '0;
    b         <= '0;
    wait (rst_n === 1'b1);
    repeat (2) @(posedge clk);
    run_op(OP_ADD, 1'b0, 32'hffff_ffff, 32'h1);
    run_op(OP_SUB, 1'b0, 32'h0, 32'h1);
    run_op(OP_SLT, 1'b1, 32'h8000_0000, 32'h0);
    run_op(OP_SLT, 1'b0, 32'h8000_0000, 32'h0);
    run_op(OP_SHR, 1'b1, 32'h8000_0000, 32'h1f);
    run_op(OP_SHR, 1'b0, 32'hf000_0000, 32'h25);
    run_op(OP_MUL, 1'b1, 32'h8000_0000, 32'h8000_0000);
    run_op(OP_MUL, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
    run_op(OP_DIV, 1'b1, 32'h8000_0000, 32'hffff_ffff);
    run_op(OP_DIV, 1'b1, 32'hffff_fff9, 32'h2);
    run_op(OP_DIV, 1'b1, 32'h7, 32'hffff_fffe);
    run_op(OP_DIV, 1'b1, 32'hffff_fff9, 32'h0);
    run_op(OP_DIV, 1'b0, 32'h1234_5678, 32'h0);
    for (int i = 0; i < N_RANDOM; i++) begin
      ro = pick_op();
      rs = lfsr_bit();
      ra = pick_operand();
      rb = pick_operand();
      run_op(ro, rs, ra, rb);
    end
    repeat (2) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("%0d operations never reported done", exp_q.size());
      stop_on_error();
    end
  end

  // Checker samples at the falling edge
  initial begin
    logic   in_flight;
    logic   seen_done;
    dword_t exp;
    in_flight = 1'b0;
    seen_done = 1'b0;
    @(negedge clk iff rst_n);
    check_flag("done after reset", done, 1'b0);
    check_flag("busy after reset", busy, 1'b0);
    forever begin
      if (!seen_done && !done) begin
        check_word("result before first done", result, '0);
        check_word("result_ext before first done", result_ext, '0);
      end
      if (done) begin
        if (!in_flight || exp_q.size() == 0) begin
          $display("done pulsed at %0d ns with no operation in flight", $time);
          stop_on_error();
        end
        exp = exp_q.pop_front();
        check_word("result", result, exp[DATA_W-1:0]);
        check_word("result_ext", result_ext, exp[2*DATA_W-1:DATA_W]);
        check_flag("busy in done cycle", busy, 1'b0);
        check_latency(cycle - start_q.pop_front(), lat_q.pop_front());
        in_flight = 1'b0;
        seen_done = 1'b1;
      end else if (in_flight) begin
        check_flag("busy while running", busy, 1'b1);
      end
      if (start && !busy) begin
        start_q.push_back(cycle);
        in_flight = 1'b1;
      end
      @(negedge clk);
    end
  end

  initial begin
    #(LIMIT_CYCLES * CLK_NS);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    stop_on_error();
  end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// ----------------------------------------
// Testbench clock and reset
// 8 ns clock, reset low for 5 cycles
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_NS    = 4;
  localparam int RST_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== design/arith_unit.sv ====
// ----------------------------------------
// Multi-cycle integer arithmetic unit
// Control plus ALU, multiplier, divider
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arith_unit import arith_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  op_e   op,
  input  logic  is_signed,
  input  word_t a,
  input  word_t b,
  output logic  done,
  output logic  busy,
  output word_t result,
  output word_t result_ext
);

  unit_if alu_bus ();
  unit_if mul_bus ();
  unit_if div_bus ();

  arith_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .op         (op),
    .is_signed  (is_signed),
    .a          (a),
    .b          (b),
    .done       (done),
    .busy       (busy),
    .result     (result),
    .result_ext (result_ext),
    .alu        (alu_bus),
    .mul        (mul_bus),
    .div        (div_bus)
  );

  alu_short u_alu (.clk(clk), .rst_n(rst_n), .port(alu_bus));

  mul_pipe u_mul (.clk(clk), .rst_n(rst_n), .port(mul_bus));

  div_sign u_div (.clk(clk), .rst_n(rst_n), .port(div_bus));

endmodule

`default_nettype wire

// ==== design/arith_ctrl.sv ====
// ----------------------------------------
// Arithmetic unit control
// Accepts one operation, steers it to a
// unit and registers the unit's result
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arith_ctrl import arith_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  op_e   op,
  input  logic  is_signed,
  input  word_t a,
  input  word_t b,
  output logic  done,
  output logic  busy,
  output word_t result,
  output word_t result_ext,
  unit_if.ctrl  alu,
  unit_if.ctrl  mul,
  unit_if.ctrl  div
);

  logic  accept;
  logic  unit_done;
  op_e   op_q;
  logic  sgn_q;
  word_t a_q;
  word_t b_q;
  op_e   op_cur;
  logic  sgn_cur;
  word_t a_cur;
  word_t b_cur;

  assign accept    = start && !busy;
  assign unit_done = alu.done || mul.done || div.done;

  // Operands hold in registers while a unit runs
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q  <= op;
      sgn_q <= is_signed;
      a_q   <= a;
      b_q   <= b;
    end
  end

  // The accept cycle sees the live inputs
  assign op_cur  = accept ? op : op_q;
  assign sgn_cur = accept ? is_signed : sgn_q;
  assign a_cur   = accept ? a : a_q;
  assign b_cur   = accept ? b : b_q;

  assign mul.start = accept && (op == OP_MUL);
  assign div.start = accept && (op == OP_DIV);
  // Unknown codes fall to the ALU so busy always clears
  assign alu.start = accept && (op != OP_MUL) && (op != OP_DIV);

  assign alu.op = op_cur;
  assign mul.op = op_cur;
  assign div.op = op_cur;
  assign {alu.is_signed, mul.is_signed, div.is_signed} = {3{sgn_cur}};
  assign {alu.a, mul.a, div.a} = {a_cur, a_cur, a_cur};
  assign {alu.b, mul.b, div.b} = {b_cur, b_cur, b_cur};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      done       <= 1'b0;
      result     <= '0;
      result_ext <= '0;
    end else begin
      done <= unit_done;
      if (accept) begin
        busy <= 1'b1;
      end else if (unit_done) begin
        busy <= 1'b0;
      end
      if (alu.done) begin
        result     <= alu.lo;
        result_ext <= alu.hi;
      end else if (mul.done) begin
        result     <= mul.lo;
        result_ext <= mul.hi;
      end else if (div.done) begin
        result     <= div.lo;
        result_ext <= div.hi;
      end
    end
  end

  a_one_unit_done: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu.done, mul.done, div.done}));

  a_done_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    unit_done |-> busy);

endmodule

`default_nettype wire

// ==== design/div_sign.sv ====
// ----------------------------------------
// Signed or unsigned divider
// Magnitudes into div_core, then one
// cycle of sign fixup on the results
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module div_sign import arith_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  unit_if.unit port
);

  logic  neg_a_in;
  logic  neg_b_in;
  word_t mag_a;
  word_t mag_b;
  logic  neg_a_q;
  logic  neg_b_q;
  logic  zero_q;
  logic  core_done;
  word_t core_quo;
  word_t core_rem;
  logic  done_q;
  word_t lo_q;
  word_t hi_q;

  assign neg_a_in = port.is_signed & port.a[DATA_W-1];
  assign neg_b_in = port.is_signed & port.b[DATA_W-1];
  assign mag_a    = neg_a_in ? -port.a : port.a;
  // b is held by the control side for the whole run
  assign mag_b    = neg_b_in ? -port.b : port.b;

  always_ff @(posedge clk) begin
    if (port.start) begin
      neg_a_q <= neg_a_in;
      neg_b_q <= neg_b_in;
      zero_q  <= (port.b == '0);
    end
  end

  div_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (port.start),
    .dividend  (mag_a),
    .divisor   (mag_b),
    .done      (core_done),
    .quotient  (core_quo),
    .remainder (core_rem)
  );

  // Remainder fixup also restores the dividend on a zero divisor
  always_ff @(posedge clk) begin
    if (core_done) begin
      lo_q <= (!zero_q && (neg_a_q ^ neg_b_q)) ? -core_quo : core_quo;
      hi_q <= neg_a_q ? -core_rem : core_rem;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= core_done;
    end
  end

  assign port.done = done_q;
  assign port.lo   = lo_q;
  assign port.hi   = hi_q;

  a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
    port.start |-> ##DIV_LAT port.done);

endmodule

`default_nettype wire

// ==== design/div_core.sv ====
// ----------------------------------------
// Unsigned restoring divider
// One quotient bit per cycle
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module div_core import arith_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  word_t dividend,
  input  word_t divisor,
  output logic  done,
  output word_t quotient,
  output word_t remainder
);

  logic            running;
  iter_t           cnt;
  word_t           quo_q;
  word_t           rem_q;
  logic [DATA_W:0] trial;
  logic [DATA_W:0] diff;
  logic            take;

  // Shift in the next dividend bit and try the subtract
  always_comb begin
    trial = {rem_q, quo_q[DATA_W-1]};
    diff  = trial - {1'b0, divisor};
    take  = trial >= {1'b0, divisor};
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo_q <= dividend;
      rem_q <= '0;
    end else if (running) begin
      quo_q <= {quo_q[DATA_W-2:0], take};
      rem_q <= take ? diff[DATA_W-1:0] : trial[DATA_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running <= 1'b0;
      cnt     <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        cnt     <= '0;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (cnt == iter_t'(DATA_W - 1)) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  // Zero divisor always subtracts nothing, so all ones and the dividend come out
  assign quotient  = quo_q;
  assign remainder = rem_q;

  a_no_start_running: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !running);

endmodule

`default_nettype wire

// ==== design/mul_pipe.sv ====
// ----------------------------------------
// Pipelined multiplier
// Three stages, full 64-bit product,
// signed or unsigned operands
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mul_pipe import arith_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  unit_if.unit port
);

  logic [MUL_LAT-1:0] vld;
  dword_t ext_a;
  dword_t ext_b;
  dword_t op_a_q;
  dword_t op_b_q;
  dword_t prod_q;
  word_t  lo_q;
  word_t  hi_q;

  // Sign bit only replicates in signed mode
  assign ext_a = {{DATA_W{port.is_signed & port.a[DATA_W-1]}}, port.a};
  assign ext_b = {{DATA_W{port.is_signed & port.b[DATA_W-1]}}, port.b};

  // Strobe travels with its data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      vld <= {vld[MUL_LAT-2:0], port.start};
    end
  end

  // Stage 1 operands
  always_ff @(posedge clk) begin
    if (port.start) begin
      op_a_q <= ext_a;
      op_b_q <= ext_b;
    end
  end

  // Stage 2 product, low 64 bits are exact in both modes
  always_ff @(posedge clk) begin
    if (vld[0]) begin
      prod_q <= op_a_q * op_b_q;
    end
  end

  // Stage 3 split
  always_ff @(posedge clk) begin
    if (vld[1]) begin
      lo_q <= prod_q[DATA_W-1:0];
      hi_q <= prod_q[2*DATA_W-1:DATA_W];
    end
  end

  assign port.done = vld[MUL_LAT-1];
  assign port.lo   = lo_q;
  assign port.hi   = hi_q;

endmodule

`default_nettype wire

// ==== design/alu_short.sv ====
// ----------------------------------------
// Single-cycle ALU
// Add, subtract, less-than and right shift
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu_short import arith_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  unit_if.unit port
);

  shamt_t sh;
  logic   less;
  word_t  shr_arith;
  word_t  shr_logic;
  word_t  res_next;
  word_t  res_q;
  logic   done_q;

  assign sh = port.b[4:0];

  always_comb begin
    less      = port.is_signed ? ($signed(port.a) < $signed(port.b)) : (port.a < port.b);
    // Arithmetic shift keeps the sign of a
    shr_arith = $signed(port.a) >>> sh;
    shr_logic = port.a >> sh;
    case (port.op)
      OP_SUB:  res_next = port.a - port.b;
      OP_SLT:  res_next = {{(DATA_W-1){1'b0}}, less};
      OP_SHR:  res_next = port.is_signed ? shr_arith : shr_logic;
      default: res_next = port.a + port.b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (port.start) begin
      res_q <= res_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= port.start;
    end
  end

  assign port.done = done_q;
  assign port.lo   = res_q;
  assign port.hi   = '0;

endmodule

`default_nettype wire

// ==== design/unit_if.sv ====
// ----------------------------------------
// Control to datapath unit connection
// Start strobe with operands, done strobe
// with two result words
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface unit_if import arith_pkg::*; ();

  logic  start;
  op_e   op;
  logic  is_signed;
  word_t a;
  word_t b;

  logic  done;
  // lo and hi only valid while done is high
  word_t lo;
  word_t hi;

  modport ctrl (output start, op, is_signed, a, b, input done, lo, hi);

  modport unit (input start, op, is_signed, a, b, output done, lo, hi);

endinterface

`default_nettype wire

// ==== design/arith_pkg.sv ====
// ----------------------------------------
// Arithmetic unit shared definitions
// Word types, operation codes and the
// start-to-done latency of each unit
// ----------------------------------------
`default_nettype none

package arith_pkg;

  // Operand width
  localparam int unsigned DATA_W = 32;

  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [2*DATA_W-1:0] dword_t;

  // Shift amount from the low bits of operand b
  typedef logic [4:0] shamt_t;

  // Divider iteration count
  typedef logic [5:0] iter_t;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_SLT = 3'd2,
    OP_SHR = 3'd3,
    OP_MUL = 3'd4,
    OP_DIV = 3'd5
  } op_e;

  // Cycles from unit start to unit done
  localparam int unsigned ALU_LAT = 1;
  localparam int unsigned MUL_LAT = 3;
  localparam int unsigned DIV_LAT = DATA_W + 2;

endpackage

`default_nettype wire
